/* verilog/cddip_pkg.sv */
// CDDIP shared definitions.
// Stream and APB widths, FIFO sizing, CRC-32 constants and the register map.

`default_nettype none

package cddip_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Widths and sizes
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int DATA_W     = 8;
  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  // Depth must stay a power of two so the pointers wrap on their own.
  localparam int ISF_DEPTH = 4;
  localparam int ISF_PTR_W = $clog2(ISF_DEPTH);
  localparam int ISF_CNT_W = $clog2(ISF_DEPTH + 1);

  // ~~~~~~~~~~~~~~~~~~~~
  // CRC-32 (reflected)
  // ~~~~~~~~~~~~~~~~~~~~
  localparam logic [31:0] CRC_POLY   = 32'hEDB8_8320;
  localparam logic [31:0] CRC_INIT   = 32'hFFFF_FFFF;
  localparam logic [31:0] CRC_XOROUT = 32'hFFFF_FFFF;

  localparam logic [APB_DATA_W-1:0] CDDIP_ID = 32'h0CDD_0001;

  // ~~~~~~~~~~~~~~~~~~~~
  // Register map
  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [APB_ADDR_W-1:0] {
    REG_CTRL   = 12'h000,
    REG_STATUS = 12'h004,
    REG_CRC    = 12'h008,
    REG_FRAMES = 12'h00C,
    REG_BYTES  = 12'h010,
    REG_ID     = 12'h014
  } reg_addr_e;

  // Field positions inside REG_CTRL and REG_STATUS.
  localparam int CTRL_HALT_BIT   = 0;
  localparam int CTRL_INTEN_BIT  = 1;
  localparam int CTRL_CLR_BIT    = 2;
  localparam int STATUS_DONE_BIT = 0;
  localparam int STATUS_IDLE_BIT = 1;

endpackage

`default_nettype wire

/* verilog/cddip_isf.sv */
// CDDIP inbound stream FIFO.
// Small circular buffer of data and last; ready while not full,
// and the oldest entry is offered whenever it is not empty.

`timescale 1ns/100ps
`default_nettype none

module cddip_isf (
  input  wire                             clk,
  input  wire                             rst_i,
  input  wire                             ib_tvalid_i,
  input  wire                             ib_tlast_i,
  input  wire [cddip_pkg::DATA_W-1:0]     ib_tdata_i,
  output logic                            ib_tready_o,
  output logic                            rd_valid_o,
  output logic                            rd_last_o,
  output logic [cddip_pkg::DATA_W-1:0]    rd_data_o,
  input  wire                             rd_ready_i,
  output logic                            empty_o
);

  logic [cddip_pkg::DATA_W-1:0]    data_mem [cddip_pkg::ISF_DEPTH];
  logic                            last_mem [cddip_pkg::ISF_DEPTH];
  logic [cddip_pkg::ISF_PTR_W-1:0] wr_ptr_q;
  logic [cddip_pkg::ISF_PTR_W-1:0] rd_ptr_q;
  logic [cddip_pkg::ISF_CNT_W-1:0] count_q;
  logic                            wr_fire;
  logic                            rd_fire;

  assign empty_o     = (count_q == '0);
  assign ib_tready_o = (count_q != cddip_pkg::ISF_DEPTH);
  assign rd_valid_o  = ~empty_o;
  assign rd_data_o   = data_mem[rd_ptr_q];
  assign rd_last_o   = last_mem[rd_ptr_q];

  assign wr_fire = ib_tvalid_i & ib_tready_o;
  assign rd_fire = rd_valid_o & rd_ready_i;

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      data_mem[wr_ptr_q] <= ib_tdata_i;
      last_mem[wr_ptr_q] <= ib_tlast_i;
    end
  end

  // Pointers wrap naturally at the power-of-two depth.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (wr_fire && !rd_fire) begin
        count_q <= count_q + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/cddip_crc.sv */
// CDDIP CRC stage.
// One output register feeding the outbound stream, with a CRC-32 folded
// over each frame as bytes are accepted. Halt holds the byte back.

`timescale 1ns/100ps
`default_nettype none

module cddip_crc (
  input  wire                             clk,
  input  wire                             rst_i,
  input  wire                             in_valid_i,
  input  wire                             in_last_i,
  input  wire [cddip_pkg::DATA_W-1:0]     in_data_i,
  output logic                            in_ready_o,
  input  wire                             halt_i,
  output logic                            ob_tvalid_o,
  output logic                            ob_tlast_o,
  output logic [cddip_pkg::DATA_W-1:0]    ob_tdata_o,
  input  wire                             ob_tready_i,
  output logic                            byte_fire_o,
  output logic                            frame_done_o,
  output logic [31:0]                     frame_crc_o,
  output logic                            busy_o
);

  logic                          valid_q;
  logic                          last_q;
  logic [cddip_pkg::DATA_W-1:0]  data_q;
  logic                          in_frame_q;
  logic [31:0]                   crc_q;
  logic [31:0]                   fin_q;
  logic [31:0]                   crc_next;
  logic                          ob_fire;
  logic                          in_fire;

  // Bit-serial reflected CRC-32, LSB first.
  function automatic logic [31:0] crc_byte(input logic [31:0] crc,
                                           input logic [cddip_pkg::DATA_W-1:0] data);
    logic [31:0] c;
    c = crc ^ {24'h0, data};
    for (int i = 0; i < cddip_pkg::DATA_W; i++) begin
      if (c[0]) begin
        c = (c >> 1) ^ cddip_pkg::CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  assign ob_fire    = valid_q & ~halt_i & ob_tready_i;
  assign in_ready_o = ~valid_q | ob_fire;
  assign in_fire    = in_valid_i & in_ready_o;
  assign crc_next   = crc_byte(crc_q, in_data_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q    <= 1'b0;
      in_frame_q <= 1'b0;
      crc_q      <= cddip_pkg::CRC_INIT;
    end else begin
      if (in_fire) begin
        valid_q    <= 1'b1;
        in_frame_q <= ~in_last_i;
        crc_q      <= in_last_i ? cddip_pkg::CRC_INIT : crc_next;
      end else if (ob_fire) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Payload and the finished CRC travel with the byte.
  always_ff @(posedge clk) begin
    if (in_fire) begin
      data_q <= in_data_i;
      last_q <= in_last_i;
      if (in_last_i) begin
        fin_q <= crc_next ^ cddip_pkg::CRC_XOROUT;
      end
    end
  end

  assign ob_tvalid_o  = valid_q & ~halt_i;
  assign ob_tlast_o   = last_q;
  assign ob_tdata_o   = data_q;
  assign byte_fire_o  = ob_fire;
  assign frame_done_o = ob_fire & last_q;
  assign frame_crc_o  = fin_q;
  assign busy_o       = valid_q | in_frame_q;

endmodule

`default_nettype wire

/* verilog/cddip_stats.sv */
// CDDIP statistics.
// Wrapping counters of outbound bytes and frames, with a clear.

`timescale 1ns/100ps
`default_nettype none

module cddip_stats (
  input  wire                                 clk,
  input  wire                                 rst_i,
  input  wire                                 byte_fire_i,
  input  wire                                 frame_done_i,
  input  wire                                 clr_i,
  output logic [cddip_pkg::APB_DATA_W-1:0]    byte_count_o,
  output logic [cddip_pkg::APB_DATA_W-1:0]    frame_count_o
);

  logic [cddip_pkg::APB_DATA_W-1:0] byte_cnt_q;
  logic [cddip_pkg::APB_DATA_W-1:0] frame_cnt_q;

  // Clear has priority over counting events in the same cycle.
  always_ff @(posedge clk) begin
    if (rst_i || clr_i) begin
      byte_cnt_q  <= '0;
      frame_cnt_q <= '0;
    end else begin
      if (byte_fire_i) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
      if (frame_done_i) begin
        frame_cnt_q <= frame_cnt_q + 1'b1;
      end
    end
  end

  assign byte_count_o  = byte_cnt_q;
  assign frame_count_o = frame_cnt_q;

endmodule

`default_nettype wire

/* verilog/cddip_csr.sv */
// CDDIP register block.
// Decodes APB accesses without wait states and holds the control bits,
// the sticky frame-done status and the last frame CRC. Also drives the
// interrupt and idle outputs.

`timescale 1ns/100ps
`default_nettype none

module cddip_csr (
  input  wire                                 clk,
  input  wire                                 rst_i,
  input  wire [cddip_pkg::APB_ADDR_W-1:0]     apb_paddr_i,
  input  wire                                 apb_psel_i,
  input  wire                                 apb_penable_i,
  input  wire                                 apb_pwrite_i,
  input  wire [cddip_pkg::APB_DATA_W-1:0]     apb_pwdata_i,
  output logic [cddip_pkg::APB_DATA_W-1:0]    apb_prdata_o,
  output logic                                apb_pready_o,
  output logic                                apb_pslverr_o,
  input  wire                                 frame_done_i,
  input  wire [31:0]                          frame_crc_i,
  input  wire [cddip_pkg::APB_DATA_W-1:0]     frame_count_i,
  input  wire [cddip_pkg::APB_DATA_W-1:0]     byte_count_i,
  input  wire                                 isf_empty_i,
  input  wire                                 crc_busy_i,
  output logic                                halt_o,
  output logic                                stats_clr_o,
  output logic                                cddip_int_o,
  output logic                                cddip_idle_o
);

  logic        access;
  logic        wr_en;
  logic        addr_hit;
  logic        ctrl_wr;
  logic        status_wr;
  logic        halt_q;
  logic        int_en_q;
  logic        done_q;
  logic [31:0] crc_q;

  assign access = apb_psel_i & apb_penable_i;
  assign wr_en  = access & apb_pwrite_i;

  always_comb begin
    addr_hit = 1'b1;
    case (apb_paddr_i)
      cddip_pkg::REG_CTRL,
      cddip_pkg::REG_STATUS,
      cddip_pkg::REG_CRC,
      cddip_pkg::REG_FRAMES,
      cddip_pkg::REG_BYTES,
      cddip_pkg::REG_ID: addr_hit = 1'b1;
      default:           addr_hit = 1'b0;
    endcase
  end

  assign ctrl_wr   = wr_en & (apb_paddr_i == cddip_pkg::REG_CTRL);
  assign status_wr = wr_en & (apb_paddr_i == cddip_pkg::REG_STATUS);

  assign apb_pready_o  = access;
  assign apb_pslverr_o = access & ~addr_hit;

  // ~~~~~~~~~~~~~~~~~~~~
  // Control and status
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst_i) begin
      halt_q   <= 1'b0;
      int_en_q <= 1'b0;
      done_q   <= 1'b0;
      crc_q    <= '0;
    end else begin
      if (ctrl_wr) begin
        halt_q   <= apb_pwdata_i[cddip_pkg::CTRL_HALT_BIT];
        int_en_q <= apb_pwdata_i[cddip_pkg::CTRL_INTEN_BIT];
      end
      // A new frame wins over a write-one-to-clear in the same cycle.
      if (frame_done_i) begin
        done_q <= 1'b1;
      end else if (status_wr && apb_pwdata_i[cddip_pkg::STATUS_DONE_BIT]) begin
        done_q <= 1'b0;
      end
      if (frame_done_i) begin
        crc_q <= frame_crc_i;
      end
    end
  end

  assign stats_clr_o  = ctrl_wr & apb_pwdata_i[cddip_pkg::CTRL_CLR_BIT];
  assign halt_o       = halt_q;
  assign cddip_int_o  = done_q & int_en_q;
  assign cddip_idle_o = isf_empty_i & ~crc_busy_i;

  // ~~~~~~~~~~~~~~~~~~~~
  // Read mux
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    apb_prdata_o = '0;
    if (access && !apb_pwrite_i) begin
      case (apb_paddr_i)
        cddip_pkg::REG_CTRL: begin
          apb_prdata_o[cddip_pkg::CTRL_HALT_BIT]  = halt_q;
          apb_prdata_o[cddip_pkg::CTRL_INTEN_BIT] = int_en_q;
        end
        cddip_pkg::REG_STATUS: begin
          apb_prdata_o[cddip_pkg::STATUS_DONE_BIT] = done_q;
          apb_prdata_o[cddip_pkg::STATUS_IDLE_BIT] = cddip_idle_o;
        end
        cddip_pkg::REG_CRC:    apb_prdata_o = crc_q;
        cddip_pkg::REG_FRAMES: apb_prdata_o = frame_count_i;
        cddip_pkg::REG_BYTES:  apb_prdata_o = byte_count_i;
        cddip_pkg::REG_ID:     apb_prdata_o = cddip_pkg::CDDIP_ID;
        default:               apb_prdata_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/cddip_top.sv */
// CDDIP top level.
// Inbound FIFO, CRC stage, statistics and APB register block.

`timescale 1ns/100ps
`default_nettype none

module cddip_top (
  input  wire                                 clk,
  input  wire                                 rst_i,
  input  wire                                 ib_tvalid_i,
  input  wire                                 ib_tlast_i,
  input  wire [cddip_pkg::DATA_W-1:0]         ib_tdata_i,
  output logic                                ib_tready_o,
  output logic                                ob_tvalid_o,
  output logic                                ob_tlast_o,
  output logic [cddip_pkg::DATA_W-1:0]        ob_tdata_o,
  input  wire                                 ob_tready_i,
  input  wire [cddip_pkg::APB_ADDR_W-1:0]     apb_paddr_i,
  input  wire                                 apb_psel_i,
  input  wire                                 apb_penable_i,
  input  wire                                 apb_pwrite_i,
  input  wire [cddip_pkg::APB_DATA_W-1:0]     apb_pwdata_i,
  output logic [cddip_pkg::APB_DATA_W-1:0]    apb_prdata_o,
  output logic                                apb_pready_o,
  output logic                                apb_pslverr_o,
  output logic                                cddip_int_o,
  output logic                                cddip_idle_o
);

  logic                             isf_valid;
  logic                             isf_last;
  logic [cddip_pkg::DATA_W-1:0]     isf_data;
  logic                             isf_empty;
  logic                             crc_ready;
  logic                             byte_fire;
  logic                             frame_done;
  logic [31:0]                      frame_crc;
  logic                             crc_busy;
  logic                             halt;
  logic                             stats_clr;
  logic [cddip_pkg::APB_DATA_W-1:0] frame_count;
  logic [cddip_pkg::APB_DATA_W-1:0] byte_count;

  cddip_isf i_cddip_isf (
    .clk          (clk),
    .rst_i        (rst_i),
    .ib_tvalid_i  (ib_tvalid_i),
    .ib_tlast_i   (ib_tlast_i),
    .ib_tdata_i   (ib_tdata_i),
    .ib_tready_o  (ib_tready_o),
    .rd_valid_o   (isf_valid),
    .rd_last_o    (isf_last),
    .rd_data_o    (isf_data),
    .rd_ready_i   (crc_ready),
    .empty_o      (isf_empty)
  );

  cddip_crc i_cddip_crc (
    .clk          (clk),
    .rst_i        (rst_i),
    .in_valid_i   (isf_valid),
    .in_last_i    (isf_last),
    .in_data_i    (isf_data),
    .in_ready_o   (crc_ready),
    .halt_i       (halt),
    .ob_tvalid_o  (ob_tvalid_o),
    .ob_tlast_o   (ob_tlast_o),
    .ob_tdata_o   (ob_tdata_o),
    .ob_tready_i  (ob_tready_i),
    .byte_fire_o  (byte_fire),
    .frame_done_o (frame_done),
    .frame_crc_o  (frame_crc),
    .busy_o       (crc_busy)
  );

  cddip_stats i_cddip_stats (
    .clk           (clk),
    .rst_i         (rst_i),
    .byte_fire_i   (byte_fire),
    .frame_done_i  (frame_done),
    .clr_i         (stats_clr),
    .byte_count_o  (byte_count),
    .frame_count_o (frame_count)
  );

  cddip_csr i_cddip_csr (
    .clk           (clk),
    .rst_i         (rst_i),
    .apb_paddr_i   (apb_paddr_i),
    .apb_psel_i    (apb_psel_i),
    .apb_penable_i (apb_penable_i),
    .apb_pwrite_i  (apb_pwrite_i),
    .apb_pwdata_i  (apb_pwdata_i),
    .apb_prdata_o  (apb_prdata_o),
    .apb_pready_o  (apb_pready_o),
    .apb_pslverr_o (apb_pslverr_o),
    .frame_done_i  (frame_done),
    .frame_crc_i   (frame_crc),
    .frame_count_i (frame_count),
    .byte_count_i  (byte_count),
    .isf_empty_i   (isf_empty),
    .crc_busy_i    (crc_busy),
    .halt_o        (halt),
    .stats_clr_o   (stats_clr),
    .cddip_int_o   (cddip_int_o),
    .cddip_idle_o  (cddip_idle_o)
  );

endmodule

`default_nettype wire

/* tests/cddip_tb.sv */
// CDDIP testbench.
// Directed tests of reset values, the frame CRC, the interrupt,
// halt with back-pressure and the statistics counters.

`timescale 1ns/100ps
`default_nettype none

module cddip_tb;

  localparam int TIMEOUT = 200;

  logic                             clk = 1'b0;
  logic                             rst;
  logic                             ib_tvalid;
  logic                             ib_tlast;
  logic [cddip_pkg::DATA_W-1:0]     ib_tdata;
  logic                             ob_tready;
  logic [cddip_pkg::APB_ADDR_W-1:0] paddr;
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [cddip_pkg::APB_DATA_W-1:0] pwdata;
  wire                              ib_tready;
  wire                              ob_tvalid;
  wire                              ob_tlast;
  wire  [cddip_pkg::DATA_W-1:0]     ob_tdata;
  wire  [cddip_pkg::APB_DATA_W-1:0] prdata;
  wire                              pready;
  wire                              pslverr;
  wire                              cddip_int;
  wire                              cddip_idle;

  integer     seed = 32'h76160f5a;
  int         errors = 0;
  int         checks = 0;
  int         tot_frames = 0;
  int         tot_bytes = 0;
  logic [7:0] tx_q[$];
  logic [7:0] rx_q[$];
  logic       rx_last_q[$];

  always #20 clk = ~clk;

  cddip_top i_cddip_top (
    .clk (clk), .rst_i (rst),
    .ib_tvalid_i (ib_tvalid), .ib_tlast_i (ib_tlast), .ib_tdata_i (ib_tdata),
    .ib_tready_o (ib_tready),
    .ob_tvalid_o (ob_tvalid), .ob_tlast_o (ob_tlast), .ob_tdata_o (ob_tdata),
    .ob_tready_i (ob_tready),
    .apb_paddr_i (paddr), .apb_psel_i (psel), .apb_penable_i (penable),
    .apb_pwrite_i (pwrite), .apb_pwdata_i (pwdata), .apb_prdata_o (prdata),
    .apb_pready_o (pready), .apb_pslverr_o (pslverr),
    .cddip_int_o (cddip_int), .cddip_idle_o (cddip_idle)
  );

  // Reference CRC-32 over tx_q, shifting in one data bit at a time.
  function automatic logic [31:0] crc32_ref();
    logic [31:0] crc;
    logic        fb;
    crc = 32'hFFFF_FFFF;
    foreach (tx_q[i]) begin
      for (int b = 0; b < 8; b++) begin
        fb  = crc[0] ^ tx_q[i][b];
        crc = crc >> 1;
        if (fb) begin
          crc = crc ^ 32'hEDB8_8320;
        end
      end
    end
    return ~crc;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s at %0t ns", what, $time);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("tests failed");
    $finish;
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // APB tasks
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic apb_access(input logic [11:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    paddr   <= addr;
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    // The block has no wait states, so the access completes on this edge.
    check_value(pready, 1'b1, "APB pready");
    rdata = prdata;
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b1, data, rdata, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(addr, 1'b0, 32'h0, data, err);
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                            input string what);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_value(data, exp, what);
    check_value(err, 1'b0, {what, " pslverr"});
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Stream tasks
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic make_random_frame(input int n);
    logic [31:0] r;
    tx_q.delete();
    repeat (n) begin
      r = $random(seed);
      tx_q.push_back(r[7:0]);
    end
  endtask

  task automatic send_frame();
    int i;
    int wait_cnt;
    i = 0;
    wait_cnt = 0;
    @(posedge clk);
    ib_tvalid <= 1'b1;
    ib_tdata  <= tx_q[0];
    ib_tlast  <= (tx_q.size() == 1);
    while (i < tx_q.size()) begin
      @(posedge clk);
      if (ib_tready) begin
        i++;
        wait_cnt = 0;
        if (i < tx_q.size()) begin
          ib_tdata <= tx_q[i];
          ib_tlast <= (i == tx_q.size() - 1);
        end else begin
          ib_tvalid <= 1'b0;
          ib_tlast  <= 1'b0;
        end
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          stop_on_timeout("inbound ready");
        end
      end
    end
  endtask

  task automatic collect_frame(input int n, input logic rand_ready);
    int          wait_cnt;
    logic [31:0] r;
    wait_cnt = 0;
    rx_q.delete();
    rx_last_q.delete();
    while (rx_q.size() < n) begin
      @(posedge clk);
      if (ob_tvalid && ob_tready) begin
        rx_q.push_back(ob_tdata);
        rx_last_q.push_back(ob_tlast);
        wait_cnt = 0;
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          stop_on_timeout("outbound bytes");
        end
      end
      r = $random(seed);
      ob_tready <= rand_ready ? r[0] : 1'b1;
    end
    ob_tready <= 1'b1;
    tot_frames++;
    tot_bytes += n;
  endtask

  task automatic compare_frame();
    foreach (tx_q[i]) begin
      check_value(rx_q[i], tx_q[i], "outbound byte");
      check_value(rx_last_q[i], (i == tx_q.size() - 1), "outbound tlast");
    end
  endtask

  task automatic run_frame(input logic rand_ready);
    fork
      send_frame();
      collect_frame(tx_q.size(), rand_ready);
    join
    compare_frame();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic test_reset_values();
    logic [31:0] data;
    logic        err;
    check_value(cddip_idle, 1'b1, "idle output");
    check_value(cddip_int, 1'b0, "interrupt output");
    check_value(ob_tvalid, 1'b0, "ob_tvalid");
    read_check(cddip_pkg::REG_ID, 32'h0CDD_0001, "REG_ID");
    read_check(cddip_pkg::REG_CTRL, 32'h0, "REG_CTRL");
    read_check(cddip_pkg::REG_STATUS, 32'h2, "REG_STATUS");
    read_check(cddip_pkg::REG_CRC, 32'h0, "REG_CRC");
    read_check(cddip_pkg::REG_FRAMES, 32'h0, "REG_FRAMES");
    read_check(cddip_pkg::REG_BYTES, 32'h0, "REG_BYTES");
    apb_read(12'h0FC, data, err);
    check_value(err, 1'b1, "pslverr at 0FC");
    check_value(data, 32'h0, "read data at 0FC");
  endtask

  task automatic test_known_crc();
    tx_q.delete();
    for (int i = 0; i < 9; i++) begin
      tx_q.push_back(8'h31 + i);
    end
    run_frame(1'b0);
    read_check(cddip_pkg::REG_CRC, 32'hCBF4_3926, "REG_CRC of 123456789");
    read_check(cddip_pkg::REG_STATUS, 32'h3, "REG_STATUS after frame");
  endtask

  task automatic test_interrupt();
    apb_write(cddip_pkg::REG_STATUS, 32'h1);
    apb_write(cddip_pkg::REG_CTRL, 32'h2);
    read_check(cddip_pkg::REG_STATUS, 32'h2, "REG_STATUS cleared");
    check_value(cddip_int, 1'b0, "interrupt before frame");
    make_random_frame(5);
    run_frame(1'b0);
    read_check(cddip_pkg::REG_STATUS, 32'h3, "REG_STATUS after frame");
    check_value(cddip_int, 1'b1, "interrupt after frame");
    read_check(cddip_pkg::REG_CRC, crc32_ref(), "REG_CRC");
    apb_write(cddip_pkg::REG_STATUS, 32'h1);
    read_check(cddip_pkg::REG_STATUS, 32'h2, "REG_STATUS after clear");
    check_value(cddip_int, 1'b0, "interrupt after clear");
  endtask

  task automatic test_halt();
    int wait_cnt;
    apb_write(cddip_pkg::REG_CTRL, 32'h1);
    make_random_frame(10);
    fork
      send_frame();
      begin
        wait_cnt = 0;
        @(posedge clk);
        // The FIFO and output register fill up while the stage is halted.
        while (ib_tready) begin
          check_value(ob_tvalid, 1'b0, "ob_tvalid while halted");
          wait_cnt++;
          if (wait_cnt > TIMEOUT) begin
            stop_on_timeout("ib_tready to drop");
          end
          @(posedge clk);
        end
        check_value(ob_tvalid, 1'b0, "ob_tvalid with FIFO full");
        check_value(cddip_idle, 1'b0, "idle output with FIFO full");
        read_check(cddip_pkg::REG_STATUS, 32'h0, "REG_STATUS while halted");
        apb_write(cddip_pkg::REG_CTRL, 32'h0);
        collect_frame(10, 1'b1);
      end
    join
    compare_frame();
    read_check(cddip_pkg::REG_CRC, crc32_ref(), "REG_CRC after halt");
  endtask

  task automatic test_statistics();
    logic [31:0] r;
    repeat (3) begin
      r = $random(seed);
      make_random_frame(1 + (r[7:0] % 8));
      run_frame(1'b1);
    end
    read_check(cddip_pkg::REG_FRAMES, tot_frames, "REG_FRAMES");
    read_check(cddip_pkg::REG_BYTES, tot_bytes, "REG_BYTES");
    apb_write(cddip_pkg::REG_CTRL, 32'h4);
    read_check(cddip_pkg::REG_FRAMES, 32'h0, "REG_FRAMES after clear");
    read_check(cddip_pkg::REG_BYTES, 32'h0, "REG_BYTES after clear");
    read_check(cddip_pkg::REG_CTRL, 32'h0, "REG_CTRL after clear");
  endtask

  initial begin
    rst       <= 1'b1;
    ib_tvalid <= 1'b0;
    ib_tlast  <= 1'b0;
    ib_tdata  <= '0;
    ob_tready <= 1'b1;
    paddr     <= '0;
    psel      <= 1'b0;
    penable   <= 1'b0;
    pwrite    <= 1'b0;
    pwdata    <= '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_reset_values();
    test_known_crc();
    test_interrupt();
    test_halt();
    test_statistics();
    repeat (2) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/cddip_pkg.sv
verilog/cddip_isf.sv
verilog/cddip_crc.sv
verilog/cddip_stats.sv
verilog/cddip_csr.sv
verilog/cddip_top.sv
tests/cddip_tb.sv

/* Bender.yml */
package:
  name: cddip

sources:
  - verilog/cddip_pkg.sv
  - verilog/cddip_isf.sv
  - verilog/cddip_crc.sv
  - verilog/cddip_stats.sv
  - verilog/cddip_csr.sv
  - verilog/cddip_top.sv
  - target: test
    files:
      - tests/cddip_tb.sv
